/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module sdram_controller_tb \
    -f sdram_controller.f -o sdram_controller_sim &&
./obj_dir/sdram_controller_sim || exit 1

/* sdram_controller.f */
+incdir+src
src/sdram_pkg.sv
src/sdram_ifs.sv
src/sdram_request_queue.sv
src/sdram_refresh_timer.sv
src/sdram_bank_tracker.sv
src/sdram_sequencer.sv
src/sdram_controller.sv
sim/sdram_model.sv
sim/sdram_controller_tb.sv

/* sim/sdram_controller_tb.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_controller_tb;
    localparam int NUM_REQ = 200;
    localparam int REFRESH_TIME = (NUM_REQ * 60 / `SDRAM_REFRESH_INTERVAL + 1)
                                  * (`SDRAM_T_RP + `SDRAM_T_RFC + 4) * 4;
    localparam int TIMEOUT = NUM_REQ * 60 * 4 + REFRESH_TIME;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [`SDRAM_ADDR_W-1:0] user_addr;
    logic                     rw;
    logic [`SDRAM_DATA_W-1:0] data_in;
    logic                     in_valid;
    logic [`SDRAM_DATA_W-1:0] sdram_dqi;
    logic                     busy;
    logic [`SDRAM_DATA_W-1:0] data_out;
    logic                     out_valid;
    logic                     sdram_cke;
    logic                     sdram_cs;
    logic                     sdram_ras;
    logic                     sdram_cas;
    logic                     sdram_we;
    logic [`SDRAM_BANK_W-1:0] sdram_ba;
    logic [`SDRAM_ROW_W-1:0]  sdram_a;
    logic [`SDRAM_DATA_W-1:0] sdram_dqo;
    logic                     sdram_dq_oe;

    logic [31:0] lfsr_state = 32'hae099007;

    // reference model of expected memory, open rows and outstanding work
    logic [`SDRAM_DATA_W-1:0] exp_mem [logic [`SDRAM_ADDR_W-1:0]];
    logic [`SDRAM_DATA_W-1:0] exp_reads [$];
    logic                     pend_rw [$];
    logic [`SDRAM_ADDR_W-1:0] pend_addr [$];
    logic [`SDRAM_DATA_W-1:0] pend_data [$];
    logic [`SDRAM_BANKS-1:0]  exp_open = '0;
    logic [`SDRAM_ROW_W-1:0]  exp_row [`SDRAM_BANKS];
    int                       read_cycles [$];
    int                       reads_accepted = 0;

    // command monitor state
    logic                     rst_q = 1'b1;
    logic                     rst_qq = 1'b1;
    logic [3:0]               cmd;
    logic [3:0]               exp_cmd = `SDRAM_CMD_NOP;
    logic [3:0]               last_cmd = `SDRAM_CMD_NOP;
    logic                     in_request = 1'b0;
    logic                     expect_refresh = 1'b0;
    logic                     have_last = 1'b0;
    logic                     have_refresh = 1'b0;
    logic                     cur_rw;
    logic [`SDRAM_ADDR_W-1:0] cur_addr;
    logic [`SDRAM_DATA_W-1:0] cur_data;
    logic [`SDRAM_BANK_W-1:0] cur_bank;
    logic [`SDRAM_ROW_W-1:0]  cur_row;
    logic [`SDRAM_COL_W-1:0]  cur_col;
    int                       cycle = 0;
    int                       last_cycle = 0;
    int                       last_refresh = 0;
    int                       refresh_count = 0;
    int                       reads_seen = 0;

    sdram_controller i_sdram_controller (
        .clk         (clk),
        .rst         (rst),
        .user_addr   (user_addr),
        .rw          (rw),
        .data_in     (data_in),
        .in_valid    (in_valid),
        .sdram_dqi   (sdram_dqi),
        .busy        (busy),
        .data_out    (data_out),
        .out_valid   (out_valid),
        .sdram_cke   (sdram_cke),
        .sdram_cs    (sdram_cs),
        .sdram_ras   (sdram_ras),
        .sdram_cas   (sdram_cas),
        .sdram_we    (sdram_we),
        .sdram_ba    (sdram_ba),
        .sdram_a     (sdram_a),
        .sdram_dqo   (sdram_dqo),
        .sdram_dq_oe (sdram_dq_oe)
    );

    sdram_model i_sdram_model (
        .clk   (clk),
        .cs    (sdram_cs),
        .ras   (sdram_ras),
        .cas   (sdram_cas),
        .we    (sdram_we),
        .ba    (sdram_ba),
        .a     (sdram_a),
        .dqo   (sdram_dqo),
        .dq_oe (sdram_dq_oe),
        .dqi   (sdram_dqi)
    );

    always #2 clk = ~clk;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("at time %0t: %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "protocol error");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int min_nops(input logic [3:0] c);
        case (c)
            `SDRAM_CMD_PRECHARGE: return `SDRAM_T_RP + 1;
            `SDRAM_CMD_ACTIVE:    return `SDRAM_T_RCD + 1;
            `SDRAM_CMD_REFRESH:   return `SDRAM_T_RFC + 1;
            `SDRAM_CMD_WRITE:     return `SDRAM_T_WR + 1;
            default:              return 0;
        endcase
    endfunction

    // open-row policy for the first command of a request
    function automatic logic [3:0] first_command(input logic [`SDRAM_BANK_W-1:0] b,
                                                 input logic [`SDRAM_ROW_W-1:0] r,
                                                 input logic wr);
        if (!exp_open[b]) begin
            return `SDRAM_CMD_ACTIVE;
        end else if (exp_row[b] == r) begin
            return wr ? `SDRAM_CMD_WRITE : `SDRAM_CMD_READ;
        end
        return `SDRAM_CMD_PRECHARGE;
    endfunction

    task automatic track_command(input logic [3:0] c);
        int gap;
        if (have_last) begin
            gap = cycle - last_cycle - 1;
            if (gap < min_nops(last_cmd)) begin
                fail_run($sformatf("only %0d NOP cycles after command %b", gap, last_cmd));
            end
        end
        have_last  = 1'b1;
        last_cycle = cycle;
        last_cmd   = c;
        if (expect_refresh) begin
            check_equal(32'(c), 32'(`SDRAM_CMD_REFRESH), "command after precharge-all");
            if (have_refresh && cycle - last_refresh > `SDRAM_REFRESH_INTERVAL + 40) begin
                fail_run($sformatf("%0d cycles between refreshes", cycle - last_refresh));
            end
            expect_refresh = 1'b0;
            have_refresh   = 1'b1;
            last_refresh   = cycle;
            refresh_count++;
        end else if (c == `SDRAM_CMD_PRECHARGE && sdram_a[10]) begin
            if (in_request) begin
                fail_run("precharge of all banks in the middle of a request");
            end
            expect_refresh = 1'b1;
            exp_open       = '0;
        end else begin
            if (c == `SDRAM_CMD_REFRESH) begin
                fail_run("REFRESH without a preceding precharge of all banks");
            end
            if (!in_request) begin
                if (pend_addr.size() == 0) begin
                    fail_run("command on the pins with no accepted request");
                end
                cur_rw     = pend_rw.pop_front();
                cur_addr   = pend_addr.pop_front();
                cur_data   = pend_data.pop_front();
                cur_bank   = cur_addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
                cur_row    = cur_addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
                cur_col    = cur_addr[`SDRAM_COL_W-1:0];
                exp_cmd    = first_command(cur_bank, cur_row, cur_rw);
                in_request = 1'b1;
            end
            check_equal(32'(c), 32'(exp_cmd), "command for the request");
            check_equal(32'(sdram_ba), 32'(cur_bank), "bank of the command");
            case (c)
                `SDRAM_CMD_PRECHARGE: begin
                    exp_open[cur_bank] = 1'b0;
                    exp_cmd = `SDRAM_CMD_ACTIVE;
                end
                `SDRAM_CMD_ACTIVE: begin
                    check_equal(32'(sdram_a), 32'(cur_row), "row of ACTIVATE");
                    exp_open[cur_bank] = 1'b1;
                    exp_row[cur_bank]  = cur_row;
                    exp_cmd = cur_rw ? `SDRAM_CMD_WRITE : `SDRAM_CMD_READ;
                end
                default: begin
                    // A10 low and the column at pins 9 to 2
                    check_equal(32'(sdram_a), 32'({3'b000, cur_col, 2'b00}), "column pins");
                    if (c == `SDRAM_CMD_WRITE) begin
                        check_equal(sdram_dqo, cur_data, "write data on dqo");
                    end else begin
                        read_cycles.push_back(cycle);
                    end
                    in_request = 1'b0;
                end
            endcase
        end
    endtask

    always @(posedge clk) begin
        rst_qq <= rst_q;
        rst_q  <= rst;
    end

    // outputs are sampled on the falling edge, away from register updates
    always @(negedge clk) begin
        cycle = cycle + 1;
        cmd   = {sdram_cs, sdram_ras, sdram_cas, sdram_we};
        check_equal(32'(sdram_cke), 32'(!rst_q), "cke against reset");
        check_equal(32'(sdram_dq_oe), 32'(cmd == `SDRAM_CMD_WRITE), "dq_oe with WRITE");
        if (rst_q || rst_qq) begin
            check_equal(32'(cmd), 32'(`SDRAM_CMD_NOP), "command around reset");
            check_equal(32'(busy), 32'd0, "busy around reset");
            check_equal(32'(out_valid), 32'd0, "out_valid around reset");
        end else begin
            if (cmd != `SDRAM_CMD_NOP) begin
                track_command(cmd);
            end
            if (out_valid) begin
                if (exp_reads.size() == 0 || read_cycles.size() == 0) begin
                    fail_run("out_valid with no read outstanding");
                end
                check_equal(32'(cycle - read_cycles.pop_front()),
                            32'(`SDRAM_CAS_LATENCY + 1), "cycles from READ to out_valid");
                check_equal(data_out, exp_reads.pop_front(), "read data");
                reads_seen++;
            end
        end
    end

    // one cycle with in_valid low, or a request that the full queue has to ignore
    task automatic idle_cycle();
        logic [31:0] r;
        random_bits(2, r);
        if (busy && r[1:0] == 2'b00) begin
            random_bits(23, r);
            user_addr = r[`SDRAM_ADDR_W-1:0];
            random_bits(32, r);
            data_in  = r;
            rw       = 1'b1;
            in_valid = 1'b1;
        end else begin
            in_valid = 1'b0;
        end
        @(posedge clk);
        #1;
    endtask

    // rows come from a pool of four per bank so hits and misses both occur
    task automatic make_request(output logic wr, output logic [`SDRAM_ADDR_W-1:0] addr,
                                output logic [`SDRAM_DATA_W-1:0] data);
        logic [31:0] r;
        logic [1:0]  b;
        logic [1:0]  row_sel;
        random_bits(1, r);
        wr = r[0];
        random_bits(2, r);
        b = r[1:0];
        random_bits(2, r);
        row_sel = r[1:0];
        random_bits(3, r);
        addr = {row_sel, 11'd5, b, 5'd0, r[2:0]};
        random_bits(32, r);
        data = r;
    endtask

    task automatic send_request(input logic wr, input logic [`SDRAM_ADDR_W-1:0] addr,
                                input logic [`SDRAM_DATA_W-1:0] data);
        logic accepted;
        accepted  = 1'b0;
        in_valid  = 1'b1;
        rw        = wr;
        user_addr = addr;
        data_in   = data;
        while (!accepted) begin
            // busy is settled here and decides the coming edge
            if (!busy) begin
                accepted = 1'b1;
                pend_rw.push_back(wr);
                pend_addr.push_back(addr);
                pend_data.push_back(data);
                if (wr) begin
                    exp_mem[addr] = data;
                end else begin
                    exp_reads.push_back(exp_mem.exists(addr) ? exp_mem[addr] : '0);
                    reads_accepted++;
                end
            end
            @(posedge clk);
            #1;
        end
        // the held request keeps the queue full in the cycle after acceptance
        check_equal(32'(busy), 32'd1, "busy after acceptance");
    endtask

    initial begin
        logic [31:0]              r;
        logic                     wr;
        logic [`SDRAM_ADDR_W-1:0] addr;
        logic [`SDRAM_DATA_W-1:0] data;
        int                       n;
        rst       = 1'b1;
        in_valid  = 1'b0;
        rw        = 1'b0;
        user_addr = '0;
        data_in   = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        for (n = 0; n < NUM_REQ; n++) begin
            random_bits(2, r);
            repeat (32'(r[1:0])) idle_cycle();
            make_request(wr, addr, data);
            send_request(wr, addr, data);
        end
        in_valid = 1'b0;
        while (pend_addr.size() != 0 || in_request) begin
            @(posedge clk);
        end
        // last READ returns well inside this window
        repeat (20) @(posedge clk);
        check_equal(32'(reads_seen), 32'(reads_accepted), "out_valid pulses against reads");
        check_equal(32'(refresh_count > 0), 32'd1, "refresh seen during the run");
        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout, the requests did not complete in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* sim/sdram_model.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_model (
    input  logic                     clk,
    input  logic                     cs,
    input  logic                     ras,
    input  logic                     cas,
    input  logic                     we,
    input  logic [`SDRAM_BANK_W-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]  a,
    input  logic [`SDRAM_DATA_W-1:0] dqo,
    input  logic                     dq_oe,
    output logic [`SDRAM_DATA_W-1:0] dqi
);
    logic [3:0]               cmd;
    logic [`SDRAM_ADDR_W-1:0] key;
    logic [`SDRAM_ROW_W-1:0]  open_row [`SDRAM_BANKS];
    logic [`SDRAM_DATA_W-1:0] mem [logic [`SDRAM_ADDR_W-1:0]];
    // read data delay line, last stage drives dqi
    logic [`SDRAM_DATA_W-1:0] rd_pipe [`SDRAM_CAS_LATENCY] = '{default: '0};

    assign cmd = {cs, ras, cas, we};
    // memory word is picked by bank, open row of that bank and column
    assign key = {open_row[ba], ba, a[`SDRAM_COL_W+1:2]};

    always @(posedge clk) begin
        if (cmd == `SDRAM_CMD_ACTIVE) begin
            open_row[ba] <= a;
        end
        if (cmd == `SDRAM_CMD_WRITE && dq_oe) begin
            mem[key] = dqo;
        end
        if (cmd == `SDRAM_CMD_READ && mem.exists(key)) begin
            rd_pipe[0] <= mem[key];
        end else begin
            rd_pipe[0] <= '0;
        end
        for (int i = 1; i < `SDRAM_CAS_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign dqi = rd_pipe[`SDRAM_CAS_LATENCY-1];

endmodule

`default_nettype wire

/* src/sdram_bank_tracker.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_bank_tracker (
    input  logic         clk,
    input  logic         rst,
    sdram_bank_if.tracker bank
);
    logic [`SDRAM_BANKS-1:0] open_q;
    logic [`SDRAM_ROW_W-1:0] row_q [`SDRAM_BANKS];

    // lookup is combinational on the requested bank
    assign bank.bank_open = open_q[bank.bank];
    assign bank.row_hit   = open_q[bank.bank] && (row_q[bank.bank] == bank.row);

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (bank.precharge) begin
                if (bank.precharge_all) begin
                    open_q <= '0;
                end else begin
                    open_q[bank.bank] <= 1'b0;
                end
            end
            if (bank.activate) begin
                open_q[bank.bank] <= 1'b1;
            end
        end
    end

    // row number of the open page
    always_ff @(posedge clk) begin
        if (bank.activate) begin
            row_q[bank.bank] <= bank.row;
        end
    end

    // sequencer must close a bank before opening another row in it
    a_no_activate_open: assert property (@(posedge clk) disable iff (rst)
        bank.activate |-> !bank.bank_open);

endmodule

`default_nettype wire

/* src/sdram_consts.svh */
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// user address fields
`define SDRAM_ROW_W 13
`define SDRAM_BANK_W 2
`define SDRAM_COL_W 8
`define SDRAM_ADDR_W 23
`define SDRAM_DATA_W 32
`define SDRAM_BANKS 4
`define SDRAM_ROW_LSB 10
`define SDRAM_BANK_LSB 8

// extra wait cycles after each command
`define SDRAM_T_RP 2
`define SDRAM_T_RCD 2
`define SDRAM_T_RFC 6
`define SDRAM_T_WR 2
`define SDRAM_CAS_LATENCY 3

`define SDRAM_REFRESH_INTERVAL 750

// {cs, ras, cas, we}
`define SDRAM_CMD_NOP 4'b0111
`define SDRAM_CMD_ACTIVE 4'b0011
`define SDRAM_CMD_READ 4'b0101
`define SDRAM_CMD_WRITE 4'b0100
`define SDRAM_CMD_PRECHARGE 4'b0010
`define SDRAM_CMD_REFRESH 4'b0001
`define SDRAM_CMD_DESELECT 4'b1000

`endif

/* src/sdram_controller.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SDRAM_ADDR_W-1:0] user_addr,
    input  logic                     rw,
    input  logic [`SDRAM_DATA_W-1:0] data_in,
    input  logic                     in_valid,
    input  logic [`SDRAM_DATA_W-1:0] sdram_dqi,
    output logic                     busy,
    output logic [`SDRAM_DATA_W-1:0] data_out,
    output logic                     out_valid,
    output logic                     sdram_cke,
    output logic                     sdram_cs,
    output logic                     sdram_ras,
    output logic                     sdram_cas,
    output logic                     sdram_we,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_DATA_W-1:0] sdram_dqo,
    output logic                     sdram_dq_oe
);
    logic refresh_pending;
    logic refresh_ack;

    sdram_req_if  req_if ();
    sdram_bank_if bank_if ();

    sdram_request_queue i_request_queue (
        .clk       (clk),
        .rst       (rst),
        .user_addr (user_addr),
        .rw        (rw),
        .data_in   (data_in),
        .in_valid  (in_valid),
        .busy      (busy),
        .req       (req_if.queue)
    );

    sdram_refresh_timer i_refresh_timer (
        .clk             (clk),
        .rst             (rst),
        .refresh_ack     (refresh_ack),
        .refresh_pending (refresh_pending)
    );

    sdram_bank_tracker i_bank_tracker (
        .clk  (clk),
        .rst  (rst),
        .bank (bank_if.tracker)
    );

    sdram_sequencer i_sequencer (
        .clk             (clk),
        .rst             (rst),
        .refresh_pending (refresh_pending),
        .sdram_dqi       (sdram_dqi),
        .refresh_ack     (refresh_ack),
        .data_out        (data_out),
        .out_valid       (out_valid),
        .sdram_cke       (sdram_cke),
        .sdram_cs        (sdram_cs),
        .sdram_ras       (sdram_ras),
        .sdram_cas       (sdram_cas),
        .sdram_we        (sdram_we),
        .sdram_ba        (sdram_ba),
        .sdram_a         (sdram_a),
        .sdram_dqo       (sdram_dqo),
        .sdram_dq_oe     (sdram_dq_oe),
        .req             (req_if.sequencer),
        .bank            (bank_if.sequencer)
    );

endmodule

`default_nettype wire

/* src/sdram_ifs.sv */
`default_nettype none

`include "sdram_consts.svh"

// one pending user request, handed over on valid and take
interface sdram_req_if;
    logic                     valid;
    logic                     rw;
    logic [`SDRAM_ADDR_W-1:0] addr;
    logic [`SDRAM_DATA_W-1:0] wdata;
    logic                     take;

    modport queue (output valid, rw, addr, wdata, input take);
    modport sequencer (input valid, rw, addr, wdata, output take);
endinterface

// open-row lookup and update strobes
interface sdram_bank_if;
    logic [`SDRAM_BANK_W-1:0] bank;
    logic [`SDRAM_ROW_W-1:0]  row;
    logic                     activate;
    logic                     precharge;
    logic                     precharge_all;
    logic                     row_hit;
    logic                     bank_open;

    modport sequencer (
        output bank, row, activate, precharge, precharge_all,
        input  row_hit, bank_open
    );
    modport tracker (
        input  bank, row, activate, precharge, precharge_all,
        output row_hit, bank_open
    );
endinterface

`default_nettype wire

/* src/sdram_pkg.sv */
`default_nettype none

`include "sdram_consts.svh"

package sdram_pkg;

    // column view of the address pins, used by read, write and precharge
    typedef struct packed {
        logic [1:0]              unused;
        // precharge all banks when set
        logic                    a10;
        logic [`SDRAM_COL_W-1:0] column;
        logic [1:0]              zero;
    } sdram_col_t;

    // address pins carry a row for activate, a column otherwise
    typedef union packed {
        logic [`SDRAM_ROW_W-1:0] row;
        sdram_col_t              col;
    } sdram_addr_u;

endpackage

`default_nettype wire

/* src/sdram_refresh_timer.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic refresh_ack,
    output logic refresh_pending
);
    localparam int CNT_W = $clog2(`SDRAM_REFRESH_INTERVAL);

    logic [CNT_W-1:0] count_q;
    logic             pending_q;
    logic             wrap;

    assign wrap = (count_q == CNT_W'(`SDRAM_REFRESH_INTERVAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            count_q <= wrap ? '0 : count_q + 1'b1;
            // a new interval wins over an ack in the same cycle
            if (wrap) begin
                pending_q <= 1'b1;
            end else if (refresh_ack) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign refresh_pending = pending_q;

endmodule

`default_nettype wire

/* src/sdram_request_queue.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_request_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SDRAM_ADDR_W-1:0] user_addr,
    input  logic                     rw,
    input  logic [`SDRAM_DATA_W-1:0] data_in,
    input  logic                     in_valid,
    output logic                     busy,
    sdram_req_if.queue               req
);
    logic                     full_q;
    logic                     capture;
    logic                     rw_q;
    logic [`SDRAM_ADDR_W-1:0] addr_q;
    logic [`SDRAM_DATA_W-1:0] data_q;

    // requests arriving while full are dropped
    assign capture = in_valid && !full_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (capture) begin
            full_q <= 1'b1;
        end else if (req.take) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rw_q   <= rw;
            addr_q <= user_addr;
            data_q <= data_in;
        end
    end

    assign busy      = full_q;
    assign req.valid = full_q;
    assign req.rw    = rw_q;
    assign req.addr  = addr_q;
    assign req.wdata = data_q;

    // sequencer only takes a held request
    a_take_when_full: assert property (@(posedge clk) disable iff (rst)
        req.take |-> full_q);

endmodule

`default_nettype wire

/* src/sdram_sequencer.sv */
`default_nettype none

`include "sdram_consts.svh"

module sdram_sequencer
    import sdram_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     refresh_pending,
    input  logic [`SDRAM_DATA_W-1:0] sdram_dqi,
    output logic                     refresh_ack,
    output logic [`SDRAM_DATA_W-1:0] data_out,
    output logic                     out_valid,
    output logic                     sdram_cke,
    output logic                     sdram_cs,
    output logic                     sdram_ras,
    output logic                     sdram_cas,
    output logic                     sdram_we,
    output logic [`SDRAM_BANK_W-1:0] sdram_ba,
    output logic [`SDRAM_ROW_W-1:0]  sdram_a,
    output logic [`SDRAM_DATA_W-1:0] sdram_dqo,
    output logic                     sdram_dq_oe,
    sdram_req_if.sequencer           req,
    sdram_bank_if.sequencer          bank
);
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_PRECHARGE = 3'd1;
    localparam logic [2:0] ST_ACTIVATE  = 3'd2;
    localparam logic [2:0] ST_READ      = 3'd3;
    localparam logic [2:0] ST_READ_CAP  = 3'd4;
    localparam logic [2:0] ST_WRITE     = 3'd5;
    localparam logic [2:0] ST_REFRESH   = 3'd6;
    localparam logic [2:0] ST_WAIT      = 3'd7;

    logic [2:0]               state_q, state_d;
    logic [2:0]               ret_q, ret_d;
    logic [3:0]               wait_q, wait_d;
    logic                     pre_all_q;
    logic                     op_rw;
    logic [`SDRAM_ADDR_W-1:0] op_addr;
    logic [`SDRAM_DATA_W-1:0] op_wdata;
    logic [`SDRAM_BANK_W-1:0] op_bank;
    logic [`SDRAM_ROW_W-1:0]  op_row;
    logic [3:0]               cmd_q, cmd_d;
    logic [`SDRAM_BANK_W-1:0] ba_q, ba_d;
    sdram_addr_u              a_q, a_d;
    logic [`SDRAM_DATA_W-1:0] dqo_q;
    logic                     oe_q, oe_d;
    logic                     cke_q;
    logic                     out_valid_q;
    logic [`SDRAM_DATA_W-1:0] data_q;

    assign op_bank = op_addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W];
    assign op_row  = op_addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];

    // idle looks up the queued request, later states the latched one
    assign bank.bank = (state_q == ST_IDLE) ?
                       req.addr[`SDRAM_BANK_LSB +: `SDRAM_BANK_W] : op_bank;
    assign bank.row  = (state_q == ST_IDLE) ?
                       req.addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W] : op_row;
    assign bank.precharge_all = pre_all_q;

    always_comb begin
        state_d        = state_q;
        ret_d          = ret_q;
        wait_d         = wait_q;
        cmd_d          = `SDRAM_CMD_NOP;
        ba_d           = '0;
        a_d            = '0;
        oe_d           = 1'b0;
        refresh_ack    = 1'b0;
        req.take       = 1'b0;
        bank.activate  = 1'b0;
        bank.precharge = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // refresh first, then the queued request
                if (refresh_pending) begin
                    refresh_ack = 1'b1;
                    state_d     = ST_PRECHARGE;
                    ret_d       = ST_REFRESH;
                end else if (req.valid) begin
                    req.take = 1'b1;
                    if (bank.row_hit) begin
                        state_d = req.rw ? ST_WRITE : ST_READ;
                    end else if (bank.bank_open) begin
                        state_d = ST_PRECHARGE;
                        ret_d   = ST_ACTIVATE;
                    end else begin
                        state_d = ST_ACTIVATE;
                    end
                end
            end
            ST_PRECHARGE: begin
                cmd_d          = `SDRAM_CMD_PRECHARGE;
                a_d.col.a10    = pre_all_q;
                ba_d           = op_bank;
                bank.precharge = 1'b1;
                wait_d         = 4'(`SDRAM_T_RP);
                state_d        = ST_WAIT;
            end
            ST_ACTIVATE: begin
                cmd_d         = `SDRAM_CMD_ACTIVE;
                a_d.row       = op_row;
                ba_d          = op_bank;
                bank.activate = 1'b1;
                wait_d        = 4'(`SDRAM_T_RCD);
                ret_d         = op_rw ? ST_WRITE : ST_READ;
                state_d       = ST_WAIT;
            end
            ST_READ: begin
                cmd_d          = `SDRAM_CMD_READ;
                a_d.col.column = op_addr[`SDRAM_COL_W-1:0];
                ba_d           = op_bank;
                // land in capture when the data is on dqi
                wait_d         = 4'(`SDRAM_CAS_LATENCY - 1);
                ret_d          = ST_READ_CAP;
                state_d        = ST_WAIT;
            end
            ST_READ_CAP: begin
                state_d = ST_IDLE;
            end
            ST_WRITE: begin
                cmd_d          = `SDRAM_CMD_WRITE;
                a_d.col.column = op_addr[`SDRAM_COL_W-1:0];
                ba_d           = op_bank;
                oe_d           = 1'b1;
                // the idle cycle counts as one of the NOPs
                wait_d         = 4'(`SDRAM_T_WR - 1);
                ret_d          = ST_IDLE;
                state_d        = ST_WAIT;
            end
            ST_REFRESH: begin
                cmd_d   = `SDRAM_CMD_REFRESH;
                wait_d  = 4'(`SDRAM_T_RFC - 1);
                ret_d   = ST_IDLE;
                state_d = ST_WAIT;
            end
            default: begin
                if (wait_q == '0) begin
                    state_d = ret_q;
                end else begin
                    wait_d = wait_q - 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            ret_q       <= ST_IDLE;
            wait_q      <= '0;
            pre_all_q   <= 1'b0;
            cmd_q       <= `SDRAM_CMD_NOP;
            oe_q        <= 1'b0;
            cke_q       <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            ret_q       <= ret_d;
            wait_q      <= wait_d;
            cmd_q       <= cmd_d;
            oe_q        <= oe_d;
            cke_q       <= 1'b1;
            out_valid_q <= (state_q == ST_READ_CAP);
            if (refresh_ack) begin
                pre_all_q <= 1'b1;
            end else if (req.take) begin
                pre_all_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        ba_q  <= ba_d;
        a_q   <= a_d;
        dqo_q <= op_wdata;
        if (req.take) begin
            op_rw    <= req.rw;
            op_addr  <= req.addr;
            op_wdata <= req.wdata;
        end
        if (state_q == ST_READ_CAP) begin
            data_q <= sdram_dqi;
        end
    end

    assign sdram_cke   = cke_q;
    assign sdram_cs    = cmd_q[3];
    assign sdram_ras   = cmd_q[2];
    assign sdram_cas   = cmd_q[1];
    assign sdram_we    = cmd_q[0];
    assign sdram_ba    = ba_q;
    assign sdram_a     = a_q;
    assign sdram_dqo   = dqo_q;
    assign sdram_dq_oe = oe_q;
    assign data_out    = data_q;
    assign out_valid   = out_valid_q;

    // refresh start shows up as a precharge of all banks with pin A10 high
    a_ack_precharge_all: assert property (@(posedge clk) disable iff (rst)
        $past(refresh_ack, 2) |-> cmd_q == `SDRAM_CMD_PRECHARGE && sdram_a[10]);

    // read and write only go to the row the tracker holds open
    a_access_open_row: assert property (@(posedge clk) disable iff (rst)
        (state_q == ST_READ || state_q == ST_WRITE) |-> bank.row_hit);

endmodule

`default_nettype wire
